/* dccm_ctl_pkg.sv */
`default_nettype none

package dccm_ctl_pkg;

   // bank word geometry
   localparam int DATA_WIDTH  = 32;
   localparam int ECC_WIDTH   = 7;
   localparam int FDATA_WIDTH = DATA_WIDTH + ECC_WIDTH;   // data plus check bits
   localparam int BYTE_WIDTH  = 4;                        // bytes per bank word
   localparam int WIDTH_BITS  = 2;                        // byte offset inside a word
   localparam int BANK_BITS   = 1;                        // bank select above the offset

   // access size codes on the size ports
   localparam logic [1:0] SIZE_BYTE  = 2'b00;
   localparam logic [1:0] SIZE_HALF  = 2'b01;
   localparam logic [1:0] SIZE_WORD  = 2'b10;
   localparam logic [1:0] SIZE_DWORD = 2'b11;

   // one memory word, seen either as the raw port value or split into fields
   typedef union packed {
      logic [FDATA_WIDTH-1:0] raw;          // as carried on the memory ports
      struct packed {
         logic [ECC_WIDTH-1:0]  ecc;        // check bits in the upper part
         logic [DATA_WIDTH-1:0] data;       // payload in the lower part
      } f;
   } dccm_word_u;

endpackage

`default_nettype wire

/* dccm_rd_ctl.sv */
`timescale 1ns/1ps
`default_nettype none

module dccm_rd_ctl #(
   parameter int DCCM_BITS = 16
) (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 valid_d,
   input  logic                 load_d,
   input  logic                 store_d,
   input  logic [1:0]           size_d,
   input  logic                 addr_in_dccm_d,
   input  logic [DCCM_BITS-1:0] lsu_addr_d,        // first byte of the access
   input  logic [DCCM_BITS-1:0] end_addr_d,        // last byte of the access
   output logic                 rden_d,            // read request seen by the arbiter
   output logic                 rden,              // memory read strobe
   output logic [DCCM_BITS-1:0] rd_addr_lo,
   output logic [DCCM_BITS-1:0] rd_addr_hi,
   output logic                 rden_m,
   output logic                 rden_r
);

   logic full_word_st;   // store fully covers its words
   logic misaligned;

   assign misaligned   = lsu_addr_d[dccm_ctl_pkg::WIDTH_BITS-1:0] != '0;
   assign full_word_st = ((size_d == dccm_ctl_pkg::SIZE_WORD) ||
                          (size_d == dccm_ctl_pkg::SIZE_DWORD)) && !misaligned;

   // loads always read, stores only when they need the old word for ECC
   assign rden_d = valid_d & addr_in_dccm_d & (load_d | (store_d & ~full_word_st));

   assign rden       = rden_d;
   assign rd_addr_lo = lsu_addr_d;
   assign rd_addr_hi = end_addr_d;

   always_ff @(posedge clk) begin
      if (rst) begin
         rden_m <= 1'b0;
         rden_r <= 1'b0;
      end else begin
         rden_m <= rden_d;               // read data is back in M
         rden_r <= rden_m;
      end
   end

endmodule

`default_nettype wire

/* dccm_wr_arb.sv */
`timescale 1ns/1ps
`default_nettype none

module dccm_wr_arb #(
   parameter int DCCM_BITS = 16
) (
   input  logic                                    rden_d,
   input  logic [DCCM_BITS-1:0]                    lsu_addr_d,
   input  logic [DCCM_BITS-1:0]                    end_addr_d,
   input  logic                                    dma_wen,
   input  dccm_ctl_pkg::dccm_word_u                dma_wdata_lo,
   input  dccm_ctl_pkg::dccm_word_u                dma_wdata_hi,
   input  logic                                    stbuf_req,
   input  logic [DCCM_BITS-1:0]                    stbuf_addr,     // word aligned
   input  dccm_ctl_pkg::dccm_word_u                stbuf_word,
   input  logic                                    scrub_pending,
   input  logic                                    scrub_lo_first,
   input  logic [DCCM_BITS-1:0]                    scrub_addr_lo,
   input  logic [DCCM_BITS-1:0]                    scrub_addr_hi,
   input  dccm_ctl_pkg::dccm_word_u                scrub_word_lo,
   input  dccm_ctl_pkg::dccm_word_u                scrub_word_hi,
   output logic                                    stbuf_commit,
   output logic                                    wren,
   output logic [DCCM_BITS-1:0]                    wr_addr_lo,
   output logic [DCCM_BITS-1:0]                    wr_addr_hi,
   output logic [dccm_ctl_pkg::FDATA_WIDTH-1:0]    wr_data_lo,
   output logic [dccm_ctl_pkg::FDATA_WIDTH-1:0]    wr_data_hi
);

   localparam int WB = dccm_ctl_pkg::WIDTH_BITS;
   localparam int BB = dccm_ctl_pkg::BANK_BITS;

   logic          bank_clash;     // store buffer bank used by the D-stage read
   logic          port_free;      // no higher priority writer this cycle

   assign bank_clash = (stbuf_addr[WB +: BB] == lsu_addr_d[WB +: BB]) |
                       (stbuf_addr[WB +: BB] == end_addr_d[WB +: BB]);
   assign port_free  = ~scrub_pending & ~dma_wen;

   // a read may share the cycle as long as it sits in the other bank
   assign stbuf_commit = stbuf_req & port_free & (~rden_d | ~bank_clash);

   assign wren = scrub_pending | dma_wen | stbuf_commit;

   // priority is scrub, then DMA, then store buffer
   always_comb begin
      if (scrub_pending) begin
         if (scrub_lo_first) begin
            wr_addr_lo = scrub_addr_lo;
            wr_data_lo = scrub_word_lo.raw;
         end else begin
            wr_addr_lo = scrub_addr_hi;          // only the high bank was bad
            wr_data_lo = scrub_word_hi.raw;
         end
         wr_addr_hi = scrub_addr_hi;
         wr_data_hi = scrub_word_hi.raw;
      end else if (dma_wen) begin
         wr_addr_lo = lsu_addr_d;
         wr_addr_hi = end_addr_d;
         wr_data_lo = dma_wdata_lo.raw;
         wr_data_hi = dma_wdata_hi.raw;
      end else begin
         wr_addr_lo = stbuf_addr;                // same word on both banks
         wr_addr_hi = stbuf_addr;
         wr_data_lo = stbuf_word.raw;
         wr_data_hi = stbuf_word.raw;
      end
   end

endmodule

`default_nettype wire

/* dccm_ecc_scrub.sv */
`timescale 1ns/1ps
`default_nettype none

module dccm_ecc_scrub #(
   parameter int DCCM_BITS = 16
) (
   input  logic                       clk,
   input  logic                       rst,
   input  logic                       load_r,
   input  logic                       dma_r,
   input  logic                       commit_r,
   input  logic                       single_err_lo_r,
   input  logic                       single_err_hi_r,
   input  logic                       double_err_r,
   input  logic [DCCM_BITS-1:0]       lsu_addr_r,
   input  logic [DCCM_BITS-1:0]       end_addr_r,
   input  dccm_ctl_pkg::dccm_word_u   sec_word_lo_r,     // corrected words from the decoder
   input  dccm_ctl_pkg::dccm_word_u   sec_word_hi_r,
   input  logic                       dma_wen,
   input  logic [DCCM_BITS-1:0]       lsu_addr_d,
   input  logic [DCCM_BITS-1:0]       end_addr_d,
   output logic                       ld_single_ecc_error_r,
   output logic                       scrub_pending,
   output logic                       scrub_lo_first,
   output logic [DCCM_BITS-1:0]       scrub_addr_lo,
   output logic [DCCM_BITS-1:0]       scrub_addr_hi,
   output dccm_ctl_pkg::dccm_word_u   scrub_word_lo,
   output dccm_ctl_pkg::dccm_word_u   scrub_word_hi
);

   localparam int WB = dccm_ctl_pkg::WIDTH_BITS;

   logic single_lo;
   logic single_hi;
   logic kill_lo;                // DMA write in D overwrites the word anyway
   logic kill_hi;
   logic err_lo_ns;
   logic err_hi_ns;
   logic err_lo_q;
   logic err_hi_q;
   logic double_q;

   assign single_lo = load_r & single_err_lo_r;
   assign single_hi = load_r & single_err_hi_r;

   assign ld_single_ecc_error_r = (single_lo | single_hi) & ~double_err_r;

   // compare word index, bank bit included
   assign kill_lo = dma_wen & ((lsu_addr_d[DCCM_BITS-1:WB] == lsu_addr_r[DCCM_BITS-1:WB]) |
                               (end_addr_d[DCCM_BITS-1:WB] == lsu_addr_r[DCCM_BITS-1:WB]));
   assign kill_hi = dma_wen & ((lsu_addr_d[DCCM_BITS-1:WB] == end_addr_r[DCCM_BITS-1:WB]) |
                               (end_addr_d[DCCM_BITS-1:WB] == end_addr_r[DCCM_BITS-1:WB]));

   assign err_lo_ns = single_lo & (commit_r | dma_r) & ~kill_lo;
   assign err_hi_ns = single_hi & (commit_r | dma_r) & ~kill_hi;

   always_ff @(posedge clk) begin
      if (rst) begin
         err_lo_q <= 1'b0;
         err_hi_q <= 1'b0;
         double_q <= 1'b0;
      end else begin
         err_lo_q <= err_lo_ns;
         err_hi_q <= err_hi_ns;
         double_q <= double_err_r;
      end
   end

   // write back is R+1
   always_ff @(posedge clk) begin
      if (ld_single_ecc_error_r) begin
         scrub_addr_lo <= lsu_addr_r;
         scrub_addr_hi <= end_addr_r;
         scrub_word_lo <= sec_word_lo_r;
         scrub_word_hi <= sec_word_hi_r;
      end
   end

   assign scrub_pending  = (err_lo_q | err_hi_q) & ~double_q;
   assign scrub_lo_first = err_lo_q;

endmodule

`default_nettype wire

/* dccm_ld_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module dccm_ld_merge (
   input  logic                                  clk,
   input  logic                                  rst,
   input  logic                                  valid_m,
   input  logic                                  load_m,
   input  logic                                  addr_in_dccm_m,
   input  logic [dccm_ctl_pkg::WIDTH_BITS-1:0]   ld_offset_m,     // byte offset of the load
   input  dccm_ctl_pkg::dccm_word_u              rd_word_lo,      // memory words, raw
   input  dccm_ctl_pkg::dccm_word_u              rd_word_hi,
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   sec_data_lo_m,   // memory data after correction
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   sec_data_hi_m,
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   fwd_data_lo,     // store buffer forward
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   fwd_data_hi,
   input  logic [dccm_ctl_pkg::BYTE_WIDTH-1:0]   fwd_byteen_lo,
   input  logic [dccm_ctl_pkg::BYTE_WIDTH-1:0]   fwd_byteen_hi,
   output logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   ld_data_m,
   output logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   ld_data_corr_r
);

   localparam int DW = dccm_ctl_pkg::DATA_WIDTH;
   localparam int BW = dccm_ctl_pkg::BYTE_WIDTH;
   localparam int WB = dccm_ctl_pkg::WIDTH_BITS;

   logic [DW-1:0] ld_data_corr_m;
   logic          ld_upd_m;

   // forwarded bytes win, then right justify by the byte offset
   function automatic logic [DW-1:0] merge_shift(
      input logic [2*DW-1:0] mem,
      input logic [2*DW-1:0] fwd,
      input logic [2*BW-1:0] byteen,
      input logic            in_dccm,
      input logic [WB-1:0]   offset
   );
      logic [2*DW-1:0] merged;
      logic [2*DW-1:0] shifted;
      for (int i = 0; i < 2*BW; i++) begin
         if (byteen[i]) begin
            merged[8*i +: 8] = fwd[8*i +: 8];
         end else begin
            merged[8*i +: 8] = in_dccm ? mem[8*i +: 8] : 8'h00;
         end
      end
      shifted = merged >> (8*offset);
      return shifted[DW-1:0];
   endfunction

   assign ld_data_m = merge_shift({rd_word_hi.f.data, rd_word_lo.f.data},
                                  {fwd_data_hi, fwd_data_lo},
                                  {fwd_byteen_hi, fwd_byteen_lo},
                                  addr_in_dccm_m, ld_offset_m);

   assign ld_data_corr_m = merge_shift({sec_data_hi_m, sec_data_lo_m},
                                       {fwd_data_hi, fwd_data_lo},
                                       {fwd_byteen_hi, fwd_byteen_lo},
                                       addr_in_dccm_m, ld_offset_m);

   assign ld_upd_m = valid_m & load_m & addr_in_dccm_m;

   always_ff @(posedge clk) begin
      if (rst) begin
         ld_data_corr_r <= '0;
      end else if (ld_upd_m) begin
         ld_data_corr_r <= ld_data_corr_m;   // only DCCM loads move on
      end
   end

endmodule

`default_nettype wire

/* dccm_ctl_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dccm_ctl_top #(
   parameter int DCCM_BITS = 16
) (
   input  logic                                  clk,
   input  logic                                  rst,
   // D stage
   input  logic                                  valid_d,
   input  logic                                  load_d,
   input  logic                                  store_d,
   input  logic [1:0]                            size_d,
   input  logic                                  addr_in_dccm_d,
   input  logic [DCCM_BITS-1:0]                  lsu_addr_d,
   input  logic [DCCM_BITS-1:0]                  end_addr_d,
   // M stage
   input  logic                                  valid_m,
   input  logic                                  load_m,
   input  logic                                  addr_in_dccm_m,
   input  logic [DCCM_BITS-1:0]                  lsu_addr_m,
   input  dccm_ctl_pkg::dccm_word_u              rd_word_lo,
   input  dccm_ctl_pkg::dccm_word_u              rd_word_hi,
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   sec_data_lo_m,
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   sec_data_hi_m,
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   fwd_data_lo,
   input  logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   fwd_data_hi,
   input  logic [dccm_ctl_pkg::BYTE_WIDTH-1:0]   fwd_byteen_lo,
   input  logic [dccm_ctl_pkg::BYTE_WIDTH-1:0]   fwd_byteen_hi,
   // R stage
   input  logic                                  load_r,
   input  logic                                  dma_r,
   input  logic                                  commit_r,
   input  logic                                  single_err_lo_r,
   input  logic                                  single_err_hi_r,
   input  logic                                  double_err_r,
   input  logic [DCCM_BITS-1:0]                  lsu_addr_r,
   input  logic [DCCM_BITS-1:0]                  end_addr_r,
   input  dccm_ctl_pkg::dccm_word_u              sec_word_lo_r,
   input  dccm_ctl_pkg::dccm_word_u              sec_word_hi_r,
   // writers
   input  logic                                  dma_wen,
   input  dccm_ctl_pkg::dccm_word_u              dma_wdata_lo,
   input  dccm_ctl_pkg::dccm_word_u              dma_wdata_hi,
   input  logic                                  stbuf_req,
   input  logic [DCCM_BITS-1:0]                  stbuf_addr,
   input  dccm_ctl_pkg::dccm_word_u              stbuf_word,
   output logic                                  stbuf_commit,
   // memory port
   output logic                                  rden,
   output logic [DCCM_BITS-1:0]                  rd_addr_lo,
   output logic [DCCM_BITS-1:0]                  rd_addr_hi,
   output logic                                  wren,
   output logic [DCCM_BITS-1:0]                  wr_addr_lo,
   output logic [DCCM_BITS-1:0]                  wr_addr_hi,
   output logic [dccm_ctl_pkg::FDATA_WIDTH-1:0]  wr_data_lo,
   output logic [dccm_ctl_pkg::FDATA_WIDTH-1:0]  wr_data_hi,
   // pipe results
   output logic                                  rden_m,
   output logic                                  rden_r,
   output logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   ld_data_m,
   output logic [dccm_ctl_pkg::DATA_WIDTH-1:0]   ld_data_corr_r,
   output logic                                  ld_single_ecc_error_r
);

   logic                       rden_d;
   logic                       scrub_pending;
   logic                       scrub_lo_first;
   logic [DCCM_BITS-1:0]       scrub_addr_lo;
   logic [DCCM_BITS-1:0]       scrub_addr_hi;
   dccm_ctl_pkg::dccm_word_u   scrub_word_lo;
   dccm_ctl_pkg::dccm_word_u   scrub_word_hi;

   dccm_rd_ctl #(.DCCM_BITS(DCCM_BITS)) rd_ctl_i (
      .clk(clk), .rst(rst),
      .valid_d(valid_d), .load_d(load_d), .store_d(store_d), .size_d(size_d),
      .addr_in_dccm_d(addr_in_dccm_d), .lsu_addr_d(lsu_addr_d), .end_addr_d(end_addr_d),
      .rden_d(rden_d), .rden(rden), .rd_addr_lo(rd_addr_lo), .rd_addr_hi(rd_addr_hi),
      .rden_m(rden_m), .rden_r(rden_r)
   );

   dccm_wr_arb #(.DCCM_BITS(DCCM_BITS)) wr_arb_i (
      .rden_d(rden_d), .lsu_addr_d(lsu_addr_d), .end_addr_d(end_addr_d),
      .dma_wen(dma_wen), .dma_wdata_lo(dma_wdata_lo), .dma_wdata_hi(dma_wdata_hi),
      .stbuf_req(stbuf_req), .stbuf_addr(stbuf_addr), .stbuf_word(stbuf_word),
      .scrub_pending(scrub_pending), .scrub_lo_first(scrub_lo_first),
      .scrub_addr_lo(scrub_addr_lo), .scrub_addr_hi(scrub_addr_hi),
      .scrub_word_lo(scrub_word_lo), .scrub_word_hi(scrub_word_hi),
      .stbuf_commit(stbuf_commit), .wren(wren),
      .wr_addr_lo(wr_addr_lo), .wr_addr_hi(wr_addr_hi),
      .wr_data_lo(wr_data_lo), .wr_data_hi(wr_data_hi)
   );

   dccm_ecc_scrub #(.DCCM_BITS(DCCM_BITS)) scrub_i (
      .clk(clk), .rst(rst),
      .load_r(load_r), .dma_r(dma_r), .commit_r(commit_r),
      .single_err_lo_r(single_err_lo_r), .single_err_hi_r(single_err_hi_r),
      .double_err_r(double_err_r), .lsu_addr_r(lsu_addr_r), .end_addr_r(end_addr_r),
      .sec_word_lo_r(sec_word_lo_r), .sec_word_hi_r(sec_word_hi_r),
      .dma_wen(dma_wen), .lsu_addr_d(lsu_addr_d), .end_addr_d(end_addr_d),
      .ld_single_ecc_error_r(ld_single_ecc_error_r), .scrub_pending(scrub_pending),
      .scrub_lo_first(scrub_lo_first),
      .scrub_addr_lo(scrub_addr_lo), .scrub_addr_hi(scrub_addr_hi),
      .scrub_word_lo(scrub_word_lo), .scrub_word_hi(scrub_word_hi)
   );

   dccm_ld_merge ld_merge_i (
      .clk(clk), .rst(rst),
      .valid_m(valid_m), .load_m(load_m), .addr_in_dccm_m(addr_in_dccm_m),
      .ld_offset_m(lsu_addr_m[dccm_ctl_pkg::WIDTH_BITS-1:0]),   // byte offset only
      .rd_word_lo(rd_word_lo), .rd_word_hi(rd_word_hi),
      .sec_data_lo_m(sec_data_lo_m), .sec_data_hi_m(sec_data_hi_m),
      .fwd_data_lo(fwd_data_lo), .fwd_data_hi(fwd_data_hi),
      .fwd_byteen_lo(fwd_byteen_lo), .fwd_byteen_hi(fwd_byteen_hi),
      .ld_data_m(ld_data_m), .ld_data_corr_r(ld_data_corr_r)
   );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD_NS    = 40,
   parameter int RESET_CYCLES = 5
) (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS/2) clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;                         // released on a rising edge
   end

endmodule

`default_nettype wire

/* dccm_ctl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dccm_ctl_tb;

   localparam int AW           = 5;          // small DCCM so that address hits are frequent
   localparam int WB           = dccm_ctl_pkg::WIDTH_BITS;
   localparam int FW           = dccm_ctl_pkg::FDATA_WIDTH;
   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 5;
   localparam logic [15:0] SEED = 16'd61715;
   localparam int RST_TIMEOUT  = 100;
   localparam int MIN_CYCLES   = 3000;
   localparam int MIN_SCRUBS   = 20;
   localparam int RUN_TIMEOUT  = 50000;

   logic clk, rst;
   logic valid_d, load_d, store_d, addr_in_dccm_d;
   logic [1:0] size_d;
   logic [AW-1:0] lsu_addr_d, end_addr_d, lsu_addr_m, lsu_addr_r, end_addr_r, stbuf_addr;
   logic valid_m, load_m, addr_in_dccm_m;
   dccm_ctl_pkg::dccm_word_u rd_word_lo, rd_word_hi, sec_word_lo_r, sec_word_hi_r;
   dccm_ctl_pkg::dccm_word_u dma_wdata_lo, dma_wdata_hi, stbuf_word;
   logic [31:0] sec_data_lo_m, sec_data_hi_m, fwd_data_lo, fwd_data_hi;
   logic [3:0] fwd_byteen_lo, fwd_byteen_hi;
   logic load_r, dma_r, commit_r, single_err_lo_r, single_err_hi_r, double_err_r;
   logic dma_wen, stbuf_req, stbuf_commit, rden, wren, rden_m, rden_r;
   logic ld_single_ecc_error_r;
   logic [AW-1:0] rd_addr_lo, rd_addr_hi, wr_addr_lo, wr_addr_hi;
   logic [FW-1:0] wr_data_lo, wr_data_hi;
   logic [31:0] ld_data_m, ld_data_corr_r;

   dccm_ctl_pkg::dccm_word_u mem [0:(1 << (AW-WB))-1];   // word index includes the bank bit
   logic [15:0] lfsr_state;
   int mismatches, other_errors, cycles, scrubs;

   // expected pipe state that moves on at every falling edge
   logic exp_rd_m, exp_rd_r, exp_err_lo_q, exp_err_hi_q, exp_dbl_q;
   logic [31:0] exp_corr_r;
   logic [AW-1:0] exp_sa_lo, exp_sa_hi;
   dccm_ctl_pkg::dccm_word_u exp_sw_lo, exp_sw_hi, e_wd_lo, e_wd_hi;
   logic e_rden, e_scrub, e_commit, e_wren, e_sec;
   logic [AW-1:0] e_wa_lo, e_wa_hi;

   tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(RESET_CYCLES)) clk_gen_i (
      .clk(clk), .rst(rst)
   );

   dccm_ctl_top #(.DCCM_BITS(AW)) dut_i (
      .clk(clk), .rst(rst), .valid_d(valid_d), .load_d(load_d), .store_d(store_d),
      .size_d(size_d), .addr_in_dccm_d(addr_in_dccm_d), .lsu_addr_d(lsu_addr_d),
      .end_addr_d(end_addr_d), .valid_m(valid_m), .load_m(load_m),
      .addr_in_dccm_m(addr_in_dccm_m), .lsu_addr_m(lsu_addr_m),
      .rd_word_lo(rd_word_lo), .rd_word_hi(rd_word_hi),
      .sec_data_lo_m(sec_data_lo_m), .sec_data_hi_m(sec_data_hi_m),
      .fwd_data_lo(fwd_data_lo), .fwd_data_hi(fwd_data_hi),
      .fwd_byteen_lo(fwd_byteen_lo), .fwd_byteen_hi(fwd_byteen_hi),
      .load_r(load_r), .dma_r(dma_r), .commit_r(commit_r),
      .single_err_lo_r(single_err_lo_r), .single_err_hi_r(single_err_hi_r),
      .double_err_r(double_err_r), .lsu_addr_r(lsu_addr_r), .end_addr_r(end_addr_r),
      .sec_word_lo_r(sec_word_lo_r), .sec_word_hi_r(sec_word_hi_r),
      .dma_wen(dma_wen), .dma_wdata_lo(dma_wdata_lo), .dma_wdata_hi(dma_wdata_hi),
      .stbuf_req(stbuf_req), .stbuf_addr(stbuf_addr), .stbuf_word(stbuf_word),
      .stbuf_commit(stbuf_commit), .rden(rden), .rd_addr_lo(rd_addr_lo),
      .rd_addr_hi(rd_addr_hi), .wren(wren), .wr_addr_lo(wr_addr_lo),
      .wr_addr_hi(wr_addr_hi), .wr_data_lo(wr_data_lo), .wr_data_hi(wr_data_hi),
      .rden_m(rden_m), .rden_r(rden_r), .ld_data_m(ld_data_m),
      .ld_data_corr_r(ld_data_corr_r), .ld_single_ecc_error_r(ld_single_ecc_error_r)
   );

   // galois LFSR stepped once per bit taken
   function logic one_bit();
      logic lsb;
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb) lfsr_state = lfsr_state ^ 16'hB400;
      return lsb;
   endfunction

   function logic [63:0] take_bits(input int n);
      logic [63:0] val;
      val = '0;
      for (int i = 0; i < n; i++) val = {val[62:0], one_bit()};
      return val;
   endfunction

   function automatic logic read_needed(input logic v, ld, st, in_dccm, input logic [1:0] sz,
                                        input logic [AW-1:0] addr);
      logic whole_words;
      whole_words = (sz >= dccm_ctl_pkg::SIZE_WORD) && (addr[WB-1:0] == 0);
      return v && in_dccm && (ld || (st && !whole_words));
   endfunction

   function automatic logic [31:0] merge_align(input logic [63:0] mem_data, fwd,
                                               input logic [7:0] be, input logic in_dccm,
                                               input logic [1:0] off);
      logic [7:0] bytes [0:7];
      int o;
      for (int b = 0; b < 8; b++) begin
         bytes[b] = be[b] ? fwd[8*b +: 8] : (in_dccm ? mem_data[8*b +: 8] : 8'h00);
      end
      o = off;
      return {bytes[o+3], bytes[o+2], bytes[o+1], bytes[o]};
   endfunction

   function automatic logic same_word(input logic [AW-1:0] a, b);
      return a[AW-1:WB] == b[AW-1:WB];
   endfunction

   function automatic logic commit_allowed(input logic req, rd, dma, scrub,
                                           input logic [AW-1:0] sb, lo, hi);
      logic other_bank;
      other_bank = (sb[WB] != lo[WB]) && (sb[WB] != hi[WB]);
      return req && ((!rd && !dma && !scrub) || (rd && other_bank && !dma && !scrub));
   endfunction

   task check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp) else begin
         $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
         mismatches++;
      end
   endtask

   task drive_random();
      logic [AW-1:0] a;
      logic [1:0] sz;
      a  = AW'(take_bits(AW));
      sz = 2'(take_bits(2));
      valid_d <= one_bit();
      load_d <= one_bit();
      store_d <= one_bit();
      addr_in_dccm_d <= one_bit() | one_bit();
      size_d <= sz;
      lsu_addr_d <= a;
      end_addr_d <= a + AW'((1 << sz) - 1);
      valid_m <= one_bit() | one_bit();
      load_m <= one_bit() | one_bit();
      addr_in_dccm_m <= one_bit() | one_bit();
      lsu_addr_m <= AW'(take_bits(AW));
      sec_data_lo_m <= 32'(take_bits(32));
      sec_data_hi_m <= 32'(take_bits(32));
      fwd_data_lo <= 32'(take_bits(32));
      fwd_data_hi <= 32'(take_bits(32));
      fwd_byteen_lo <= 4'(take_bits(4));
      fwd_byteen_hi <= 4'(take_bits(4));
      a = AW'(take_bits(AW));
      load_r <= one_bit() | one_bit();
      dma_r <= one_bit() & one_bit();
      commit_r <= one_bit();
      double_err_r <= one_bit() & one_bit() & one_bit();
      single_err_lo_r <= one_bit() & one_bit();
      single_err_hi_r <= one_bit() & one_bit();
      lsu_addr_r <= a;
      end_addr_r <= a + AW'(take_bits(3));
      sec_word_lo_r.raw <= FW'(take_bits(FW));
      sec_word_hi_r.raw <= FW'(take_bits(FW));
      dma_wen <= one_bit() & one_bit();
      dma_wdata_lo.raw <= FW'(take_bits(FW));
      dma_wdata_hi.raw <= FW'(take_bits(FW));
      if (!(stbuf_req && !stbuf_commit)) begin     // a refused request is held
         stbuf_req <= one_bit();
         stbuf_addr <= AW'(take_bits(AW-WB)) << WB;
         stbuf_word.raw <= FW'(take_bits(FW));
      end
   endtask

   // memory model returns read data one cycle after rden
   initial begin
      for (int i = 0; i < (1 << (AW-WB)); i++) begin
         mem[i].raw = {7'(i*5 + 3), 32'hc3a5_0000 ^ 32'(i * 32'h0101_1001)};
      end
      rd_word_lo = '0;
      rd_word_hi = '0;
   end

   always @(posedge clk) begin
      if (rden) begin
         rd_word_lo <= mem[rd_addr_lo[AW-1:WB]];
         rd_word_hi <= mem[rd_addr_hi[AW-1:WB]];
      end
      if (wren) begin
         mem[wr_addr_lo[AW-1:WB]].raw <= wr_data_lo;
         mem[wr_addr_hi[AW-1:WB]].raw <= wr_data_hi;
      end
   end

   // compare at the falling edge while all inputs are stable
   always @(negedge clk) begin
      if (rst) begin
         exp_rd_m = 1'b0;
         exp_rd_r = 1'b0;
         exp_corr_r = '0;
         exp_err_lo_q = 1'b0;
         exp_err_hi_q = 1'b0;
         exp_dbl_q = 1'b0;
      end else begin
         e_rden   = read_needed(valid_d, load_d, store_d, addr_in_dccm_d, size_d, lsu_addr_d);
         e_scrub  = (exp_err_lo_q || exp_err_hi_q) && !exp_dbl_q;
         e_commit = commit_allowed(stbuf_req, e_rden, dma_wen, e_scrub, stbuf_addr,
                                   lsu_addr_d, end_addr_d);
         e_wren   = e_scrub || dma_wen || e_commit;
         e_sec    = load_r && (single_err_lo_r || single_err_hi_r) && !double_err_r;
         if (e_scrub) begin
            e_wa_lo = exp_err_lo_q ? exp_sa_lo : exp_sa_hi;   // both banks get the high word
            e_wd_lo = exp_err_lo_q ? exp_sw_lo : exp_sw_hi;
            e_wa_hi = exp_sa_hi;
            e_wd_hi = exp_sw_hi;
            scrubs++;
         end else if (dma_wen) begin
            e_wa_lo = lsu_addr_d;
            e_wa_hi = end_addr_d;
            e_wd_lo = dma_wdata_lo;
            e_wd_hi = dma_wdata_hi;
         end else begin
            e_wa_lo = stbuf_addr;
            e_wa_hi = stbuf_addr;
            e_wd_lo = stbuf_word;
            e_wd_hi = stbuf_word;
         end
         check_value("rden", rden, e_rden);
         check_value("rd_addr_lo", rd_addr_lo, lsu_addr_d);
         check_value("rd_addr_hi", rd_addr_hi, end_addr_d);
         check_value("rden_m", rden_m, exp_rd_m);
         check_value("rden_r", rden_r, exp_rd_r);
         check_value("ld_data_m", ld_data_m,
                     merge_align({rd_word_hi.f.data, rd_word_lo.f.data},
                                 {fwd_data_hi, fwd_data_lo}, {fwd_byteen_hi, fwd_byteen_lo},
                                 addr_in_dccm_m, lsu_addr_m[1:0]));
         check_value("ld_data_corr_r", ld_data_corr_r, exp_corr_r);
         check_value("stbuf_commit", stbuf_commit, e_commit);
         check_value("wren", wren, e_wren);
         check_value("ld_single_ecc_error_r", ld_single_ecc_error_r, e_sec);
         if (e_wren) begin
            check_value("wr_addr_lo", wr_addr_lo, e_wa_lo);
            check_value("wr_addr_hi", wr_addr_hi, e_wa_hi);
            check_value("wr_data_lo", wr_data_lo, e_wd_lo.raw);
            check_value("wr_data_hi", wr_data_hi, e_wd_hi.raw);
         end
         exp_rd_r = exp_rd_m;
         exp_rd_m = e_rden;
         if (valid_m && load_m && addr_in_dccm_m) begin
            exp_corr_r = merge_align({sec_data_hi_m, sec_data_lo_m},
                                     {fwd_data_hi, fwd_data_lo},
                                     {fwd_byteen_hi, fwd_byteen_lo},
                                     addr_in_dccm_m, lsu_addr_m[1:0]);
         end
         // a DMA write in D to the same word makes the write-back useless
         exp_err_lo_q = load_r && single_err_lo_r && (commit_r || dma_r) &&
                        !(dma_wen && (same_word(lsu_addr_d, lsu_addr_r) ||
                                      same_word(end_addr_d, lsu_addr_r)));
         exp_err_hi_q = load_r && single_err_hi_r && (commit_r || dma_r) &&
                        !(dma_wen && (same_word(lsu_addr_d, end_addr_r) ||
                                      same_word(end_addr_d, end_addr_r)));
         exp_dbl_q = double_err_r;
         if (e_sec) begin
            exp_sa_lo = lsu_addr_r;
            exp_sa_hi = end_addr_r;
            exp_sw_lo = sec_word_lo_r;
            exp_sw_hi = sec_word_hi_r;
         end
      end
   end

   initial begin
      lfsr_state = SEED;
      mismatches = 0;
      other_errors = 0;
      cycles = 0;
      scrubs = 0;
      valid_d = 0;
      load_d = 0;
      store_d = 0;
      size_d = 0;
      addr_in_dccm_d = 0;
      lsu_addr_d = 0;
      end_addr_d = 0;
      valid_m = 0;
      load_m = 0;
      addr_in_dccm_m = 0;
      lsu_addr_m = 0;
      sec_data_lo_m = 0;
      sec_data_hi_m = 0;
      fwd_data_lo = 0;
      fwd_data_hi = 0;
      fwd_byteen_lo = 0;
      fwd_byteen_hi = 0;
      load_r = 0;
      dma_r = 0;
      commit_r = 0;
      single_err_lo_r = 0;
      single_err_hi_r = 0;
      double_err_r = 0;
      lsu_addr_r = 0;
      end_addr_r = 0;
      sec_word_lo_r = '0;
      sec_word_hi_r = '0;
      dma_wen = 0;
      dma_wdata_lo = '0;
      dma_wdata_hi = '0;
      stbuf_req = 0;
      stbuf_addr = 0;
      stbuf_word = '0;
      while (rst !== 1'b0 && cycles < RST_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      if (rst !== 1'b0) begin
         $display("timeout: reset was never released");
         other_errors++;
         $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
         $display("TESTBENCH FAILED");
         $finish;
      end else begin
         cycles = 0;
         while ((cycles < MIN_CYCLES || scrubs < MIN_SCRUBS) && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            drive_random();
            cycles++;
         end
         if (scrubs < MIN_SCRUBS) begin
            $display("timeout: only %0d ECC write-backs seen", scrubs);
            other_errors++;
         end
         @(negedge clk);
         @(posedge clk);                  // lets the last compare finish
         $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
         if (mismatches == 0 && other_errors == 0) begin
            $display("TESTBENCH PASSED");
         end else begin
            $display("TESTBENCH FAILED");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sources.f */
dccm_ctl_pkg.sv
dccm_rd_ctl.sv
dccm_wr_arb.sv
dccm_ecc_scrub.sv
dccm_ld_merge.sv
dccm_ctl_top.sv
tb_clk_gen.sv
dccm_ctl_tb.sv
